// File: Makefile
TOP = tb_msx_io

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module $(TOP) -f sources.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f sources.f -o $(TOP)
	./obj_dir/$(TOP) | tee /dev/stderr | grep -q "SIMULATION PASSED"

clean:
	rm -rf obj_dir

// File: bench/msx_io_tests.txt
# W port data | R port expected | M mem_addr ram_addr | J joy0 joy1 tape
# I irq_level | S volume period | all values in hex
M 0000 00C000
M 4567 008567
M 8123 004123
M FFFF 003FFF
W FE 21
R FE 21
M 9234 085234
R 42 FF
J 15 2A 0
W A0 0E
R A2 95
W A0 0F
W A1 40
J 15 2A 1
W A0 0E
R A2 EA
I 1
R 99 80
I 0
R 99 00
W A0 00
W A1 02
R A2 02
W A0 08
W A1 05
R A2 05
S 5 2
W A1 00
S 0 2

// File: bench/tb_msx_io.sv
`timescale 1ns/10ps

module tb_msx_io;

    localparam int FRAME_CYCLES = 200;
    localparam int PSG_DIV      = 4;

    logic               clk_sys  = 1'b0;
    logic               arst_n   = 1'b0;
    logic               req      = 1'b0;
    logic               ack;
    logic               io_wr    = 1'b0;
    logic [7:0]         io_addr  = 8'h00;
    logic [7:0]         io_wdata = 8'h00;
    logic [7:0]         io_rdata;
    logic [15:0]        mem_addr = 16'h0000;
    logic [21:0]        ram_addr;
    logic [5:0]         joy0     = 6'h00;
    logic [5:0]         joy1     = 6'h00;
    logic               tape_in  = 1'b0;
    logic               irq;
    logic signed [15:0] sound;
    string              tests [$];                          // Operation lines of the test file
    int                 n_tests  = 0;

    msx_io_top #(.FRAME_CYCLES(FRAME_CYCLES), .PSG_DIV(PSG_DIV)) u_dut (.*);

    always #2 clk_sys = ~clk_sys;

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("SIMULATION FAILED");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check(input string name, input logic [31:0] actual,
                         input logic [31:0] expected);
        if (actual !== expected)
            abort_run($sformatf("mismatch %s: got %h, expected %h", name, actual, expected));
    endtask

    // One four-phase host cycle, entered and left on a falling edge
    task automatic io_cycle(input logic wr, input int addr, input int wdata,
                            output logic [7:0] rdata);
        int waited;
        io_addr  = addr[7:0];
        io_wdata = wdata[7:0];
        io_wr    = wr;
        req      = 1'b1;
        waited   = 0;
        while (!ack) begin
            @(negedge clk_sys);
            waited++;
            if (waited > 8)
                abort_run("ack never rose after req was raised");
        end
        check("ack delay", waited, 3);                      // Sample edge, STROBE, HOLD
        rdata = io_rdata;
        @(negedge clk_sys);
        check("ack", 32'(ack), 1);
        req = 1'b0;
        repeat (2) @(negedge clk_sys);
        check("ack", 32'(ack), 0);
    endtask

    // Square wave at plus or minus the amplitude
    task automatic tone_check(input int vol, input int period);
        logic [15:0] amp;
        logic        start_sign;
        logic        flipped;
        amp        = 16'(vol * 2048);
        start_sign = sound[15];
        flipped    = 1'b0;
        repeat (4 * PSG_DIV * (period + 1)) begin
            @(negedge clk_sys);
            check("sound", {16'h0000, sound}, {16'h0000, sound[15] ? -amp : amp});
            flipped = flipped | (sound[15] != start_sign);
        end
        if (vol != 0 && !flipped)
            abort_run("sound did not change sign within the tone window");
    endtask

    initial begin
        string      line;
        int         fd;
        int         a;
        int         b;
        int         c;
        int         waited;
        logic [7:0] op;
        logic [7:0] rdata;
        fd = $fopen("bench/msx_io_tests.txt", "r");
        if (fd == 0)
            abort_run("cannot open bench/msx_io_tests.txt");
        while ($fgets(line, fd) > 0) begin
            if (line.len() > 1 && line[0] != "#")           // Skip comments and empty lines
                tests.push_back(line);
        end
        $fclose(fd);
        if (tests.size() == 0)
            abort_run("the test file holds no operations");
        n_tests = tests.size();
        repeat (3) @(negedge clk_sys);
        arst_n = 1'b1;
        foreach (tests[i]) begin
            void'($sscanf(tests[i], "%c %h %h %h", op, a, b, c));
            case (op)
                "W", "R": begin
                    io_cycle(op == "W", a, b, rdata);
                    if (op == "R")
                        check("io_rdata", 32'(rdata), b);
                end
                "M": begin
                    mem_addr = a[15:0];
                    @(negedge clk_sys);
                    check("ram_addr", 32'(ram_addr), b);
                end
                "J": begin
                    joy0    = a[5:0];
                    joy1    = b[5:0];
                    tape_in = c[0];
                end
                "I": begin
                    waited = 0;
                    while (irq !== a[0]) begin
                        @(negedge clk_sys);
                        waited++;
                        if (waited > FRAME_CYCLES)
                            abort_run("irq did not reach the expected level within a frame");
                    end
                end
                "S": tone_check(a, b);
                default: abort_run($sformatf("unknown opcode %c in the test file", op));
            endcase
        end
        $display("SIMULATION PASSED");
        $finish;
    end

    // Two frames plus slack for every test line
    initial begin
        wait (n_tests > 0);
        repeat (n_tests * (2 * FRAME_CYCLES + 100)) @(posedge clk_sys);
        abort_run("timeout, the tests did not finish within their cycle budget");
    end

endmodule

// File: hdl/cpu_bus_if.sv
`timescale 1ns/10ps

// One I/O cycle as seen by the peripherals.
// wr and rd are single-cycle strobes, addr and wdata stay valid around them.
interface cpu_bus_if;

    logic [7:0] addr;                       // Z80 I/O port number
    logic [7:0] wdata;
    logic       wr;
    logic       rd;

    modport ctrl_mp (
        output addr,
        output wdata,
        output wr,
        output rd
    );

    modport device_mp (
        input  addr,
        input  wdata,
        input  wr,
        input  rd
    );

endinterface

// File: hdl/dev_frame_irq.sv
`timescale 1ns/10ps

module dev_frame_irq #(
    parameter int FRAME_CYCLES = 1000
) (
    input  logic            clk_sys,
    input  logic            arst_n,
    cpu_bus_if.device_mp    bus,
    output logic [7:0]      data,
    output logic            irq
);
    import msx_pkg::*;

    localparam int CNT_W = (FRAME_CYCLES > 1) ? $clog2(FRAME_CYCLES) : 1;

    logic [CNT_W-1:0] frame_cnt;
    logic             frame_wrap;
    logic             stat_rd;
    logic             flag;

    assign frame_wrap = (frame_cnt == CNT_W'(FRAME_CYCLES - 1));
    assign stat_rd    = bus.rd && (bus.addr == PORT_VDP_STAT);

    always_ff @(posedge clk_sys or negedge arst_n) begin
        if (!arst_n) begin
            frame_cnt <= '0;
            flag      <= 1'b0;
        end else begin
            frame_cnt <= frame_wrap ? '0 : frame_cnt + 1'b1;
            if (frame_wrap)
                flag <= 1'b1;                               // Wins over a same-cycle read
            else if (stat_rd)
                flag <= 1'b0;
        end
    end

    // Status byte only carries the frame flag
    always_comb begin
        if (stat_rd)
            data = {flag, 7'd0};
        else
            data = DATA_IDLE;
    end

    assign irq = flag;

    a_irq_clear: assert property (@(posedge clk_sys) disable iff (!arst_n)
        $fell(irq) |-> $past(stat_rd)) else $error("irq dropped without a status read");

endmodule

// File: hdl/dev_psg.sv
`timescale 1ns/10ps

module dev_psg #(
    parameter int PSG_DIV = 16
) (
    input  logic                clk_sys,
    input  logic                arst_n,
    cpu_bus_if.device_mp        bus,
    input  logic [5:0]          joy [2],
    input  logic                tape_in,
    output logic [7:0]          data,
    output logic signed [15:0]  sound
);
    import msx_pkg::*;

    localparam int DIV_W = (PSG_DIV > 1) ? $clog2(PSG_DIV) : 1;

    logic [7:0]         reg_latch;                          // Full byte so bad numbers are visible
    logic [7:0]         regs [16];
    logic [DIV_W-1:0]   div_cnt;
    logic               tone_tick;
    logic [11:0]        tone_cnt;
    logic [11:0]        tone_period;
    logic               square;
    logic [5:0]         joy_sel;
    logic signed [15:0] amp;

    assign tone_tick   = (div_cnt == DIV_W'(PSG_DIV - 1));
    assign tone_period = {regs[PSG_REG_TONE_HI][3:0], regs[PSG_REG_TONE_LO]};
    assign joy_sel     = regs[PSG_REG_IO_B][6] ? joy[1] : joy[0];
    assign amp         = signed'({1'b0, regs[PSG_REG_VOL_A][3:0], 11'b0});   // Volume x 2048

    always_ff @(posedge clk_sys or negedge arst_n) begin
        if (!arst_n) begin
            reg_latch <= 8'd0;
            for (int i = 0; i < 16; i++) begin
                regs[i] <= 8'd0;
            end
        end else if (bus.wr) begin
            if (bus.addr == PORT_PSG_ADDR)
                reg_latch <= bus.wdata;
            if (bus.addr == PORT_PSG_WR)
                regs[reg_latch[3:0]] <= bus.wdata;
        end
    end

    always_ff @(posedge clk_sys or negedge arst_n) begin
        if (!arst_n) begin
            div_cnt  <= '0;
            tone_cnt <= 12'd0;
            square   <= 1'b0;
        end else begin
            div_cnt <= tone_tick ? '0 : div_cnt + 1'b1;
            if (tone_tick) begin
                if (tone_cnt >= tone_period) begin          // >= copes with a shortened period
                    tone_cnt <= 12'd0;
                    square   <= ~square;
                end else begin
                    tone_cnt <= tone_cnt + 12'd1;
                end
            end
        end
    end

    always_comb begin
        data = DATA_IDLE;
        if (bus.rd && bus.addr == PORT_PSG_RD) begin
            if (reg_latch[3:0] == PSG_REG_IO_A)
                data = {1'b1, tape_in, joy_sel};
            else
                data = regs[reg_latch[3:0]];
        end
    end

    assign sound = square ? amp : -amp;

    a_latch_range: assert property (@(posedge clk_sys) disable iff (!arst_n)
        reg_latch < 8'd16) else $error("PSG register latch out of range");

endmodule

// File: hdl/devices.sv
`timescale 1ns/10ps

module devices #(
    parameter int FRAME_CYCLES = 1000,
    parameter int PSG_DIV      = 16
) (
    input  logic                            clk_sys,
    input  logic                            arst_n,
    cpu_bus_if.device_mp                    bus,
    input  logic [15:0]                     mem_addr,
    input  logic [5:0]                      joy [2],
    input  logic                            tape_in,
    output logic [7:0]                      data,           // Combined read data
    output logic [msx_pkg::RAM_ADDR_W-1:0]  ram_addr,
    output logic                            cpu_interrupt,
    output logic signed [15:0]              sound
);

    wire [7:0] mapper_data;
    wire [7:0] psg_data;
    wire [7:0] vdp_data;
    wire       vdp_interrupt;

    // Idle devices drive FF, so AND picks the one that answers
    assign data          = mapper_data & psg_data & vdp_data;
    assign cpu_interrupt = vdp_interrupt;                   // Single source for now

    mapper_port mapper_port (
        .clk_sys(clk_sys),
        .arst_n(arst_n),
        .bus(bus),
        .mem_addr(mem_addr),
        .data(mapper_data),
        .ram_addr(ram_addr)
    );

    dev_psg #(.PSG_DIV(PSG_DIV)) dev_psg (
        .clk_sys(clk_sys),
        .arst_n(arst_n),
        .bus(bus),
        .joy(joy),
        .tape_in(tape_in),
        .data(psg_data),
        .sound(sound)
    );

    dev_frame_irq #(.FRAME_CYCLES(FRAME_CYCLES)) dev_frame_irq (
        .clk_sys(clk_sys),
        .arst_n(arst_n),
        .bus(bus),
        .data(vdp_data),
        .irq(vdp_interrupt)
    );
endmodule

// File: hdl/io_bus_ctrl.sv
`timescale 1ns/10ps

module io_bus_ctrl (
    input  logic         clk_sys,
    input  logic         arst_n,
    input  logic         req,
    input  logic         io_wr,
    input  logic [7:0]   io_addr,
    input  logic [7:0]   io_wdata,
    input  logic [7:0]   bus_rdata,
    output logic         ack,
    output logic [7:0]   io_rdata,
    cpu_bus_if.ctrl_mp   bus
);
    import msx_pkg::*;

    bus_state_t state;

    assign bus.addr  = io_addr;                             // Host holds these while req is high
    assign bus.wdata = io_wdata;
    assign bus.wr    = (state == STROBE) && io_wr;
    assign bus.rd    = (state == STROBE) && !io_wr;

    always_ff @(posedge clk_sys or negedge arst_n) begin
        if (!arst_n) begin
            state    <= IDLE;
            ack      <= 1'b0;
            io_rdata <= DATA_IDLE;
        end else begin
            case (state)
                IDLE: begin
                    if (req)
                        state <= STROBE;
                end
                STROBE:  state <= HOLD;
                HOLD:    state <= RELEASE;
                RELEASE: begin
                    if (!req)
                        state <= IDLE;
                end
                default: state <= IDLE;
            endcase
            ack <= (state == HOLD) || (state == RELEASE && req);
            if (bus.rd)
                io_rdata <= bus_rdata;                      // Device data is only live with rd
        end
    end

    a_strobe_excl: assert property (@(posedge clk_sys) disable iff (!arst_n)
        !(bus.wr && bus.rd)) else $error("wr and rd strobes overlap");

    a_strobe_len: assert property (@(posedge clk_sys) disable iff (!arst_n)
        (bus.wr || bus.rd) |=> !(bus.wr || bus.rd)) else $error("strobe longer than one cycle");

endmodule

// File: hdl/mapper_port.sv
`timescale 1ns/10ps

module mapper_port (
    input  logic                            clk_sys,
    input  logic                            arst_n,
    cpu_bus_if.device_mp                    bus,
    input  logic [15:0]                     mem_addr,
    output logic [7:0]                      data,
    output logic [msx_pkg::RAM_ADDR_W-1:0]  ram_addr
);
    import msx_pkg::*;

    logic [MAPPER_BITS-1:0] page_reg [4];
    logic                   port_hit;
    logic [1:0]             port_page;

    // FC..FF share the upper six address bits
    assign port_hit  = (bus.addr[7:2] == PORT_MAPPER_BASE[7:2]);
    assign port_page = bus.addr[1:0];

    always_ff @(posedge clk_sys or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < 4; i++) begin
                page_reg[i] <= MAPPER_BITS'(3 - i);         // Pages 0..3 start on segments 3..0
            end
        end else if (bus.wr && port_hit) begin
            page_reg[port_page] <= bus.wdata;
        end
    end

    always_comb begin
        if (bus.rd && port_hit)
            data = page_reg[port_page];
        else
            data = DATA_IDLE;
    end

    // Segment of the addressed 16k page, then the offset inside it
    assign ram_addr = {page_reg[mem_addr[15:14]], mem_addr[13:0]};

endmodule

// File: hdl/msx_io_top.sv
`timescale 1ns/10ps

module msx_io_top #(
    parameter int FRAME_CYCLES = 1000,
    parameter int PSG_DIV      = 16
) (
    input  logic                            clk_sys,
    input  logic                            arst_n,
    input  logic                            req,
    output logic                            ack,
    input  logic [7:0]                      io_addr,
    input  logic [7:0]                      io_wdata,
    input  logic                            io_wr,
    output logic [7:0]                      io_rdata,
    input  logic [15:0]                     mem_addr,
    output logic [msx_pkg::RAM_ADDR_W-1:0]  ram_addr,
    input  logic [5:0]                      joy0,
    input  logic [5:0]                      joy1,
    input  logic                            tape_in,
    output logic                            irq,
    output logic signed [15:0]              sound
);

    cpu_bus_if cpu_bus ();

    logic [5:0] joy [2];
    assign joy[0] = joy0;
    assign joy[1] = joy1;

    wire [7:0] bus_rdata;
    io_bus_ctrl io_bus_ctrl (
        .clk_sys(clk_sys),
        .arst_n(arst_n),
        .req(req),
        .io_wr(io_wr),
        .io_addr(io_addr),
        .io_wdata(io_wdata),
        .bus_rdata(bus_rdata),
        .ack(ack),
        .io_rdata(io_rdata),
        .bus(cpu_bus)
    );

    devices #(.FRAME_CYCLES(FRAME_CYCLES), .PSG_DIV(PSG_DIV)) devices (
        .clk_sys(clk_sys),
        .arst_n(arst_n),
        .bus(cpu_bus),
        .mem_addr(mem_addr),
        .joy(joy),
        .tape_in(tape_in),
        .data(bus_rdata),
        .ram_addr(ram_addr),
        .cpu_interrupt(irq),
        .sound(sound)
    );
endmodule

// File: hdl/msx_pkg.sv
package msx_pkg;

    // I/O port map
    localparam logic [7:0] PORT_MAPPER_BASE = 8'hFC;    // FC..FF, one per page
    localparam logic [7:0] PORT_PSG_ADDR    = 8'hA0;
    localparam logic [7:0] PORT_PSG_WR      = 8'hA1;
    localparam logic [7:0] PORT_PSG_RD      = 8'hA2;
    localparam logic [7:0] PORT_VDP_STAT    = 8'h99;

    // Value of an undriven data bus
    localparam logic [7:0] DATA_IDLE        = 8'hFF;

    // Memory mapper
    localparam int RAM_ADDR_W               = 22;       // 8 page bits + 14 offset bits
    localparam int MAPPER_BITS              = 8;

    // PSG register numbers
    localparam logic [3:0] PSG_REG_TONE_LO  = 4'd0;
    localparam logic [3:0] PSG_REG_TONE_HI  = 4'd1;
    localparam logic [3:0] PSG_REG_VOL_A    = 4'd8;
    localparam logic [3:0] PSG_REG_IO_A     = 4'd14;    // Joystick and tape input
    localparam logic [3:0] PSG_REG_IO_B     = 4'd15;    // Bit 6 picks the joystick

    // Host cycle sequencing in the bus controller
    typedef enum logic [1:0] {
        IDLE,
        STROBE,
        HOLD,
        RELEASE
    } bus_state_t;

endpackage

// File: sources.f
hdl/msx_pkg.sv
hdl/cpu_bus_if.sv
hdl/io_bus_ctrl.sv
hdl/mapper_port.sv
hdl/dev_psg.sv
hdl/dev_frame_irq.sv
hdl/devices.sv
hdl/msx_io_top.sv
bench/tb_msx_io.sv
